// ==== source/cpu_pkg.sv ====
package cpu_pkg;

	// opcode byte, seen either as a raw value or as the 8x..Fx field layout
	typedef union packed
	{
		logic [7:0] raw;
		struct packed
		{
			logic       alu_class; // set for 8x..Fx
			logic       acc_sel;   // 0 = A, 1 = B
			logic [1:0] mode;      // addressing mode
			logic [3:0] op;        // ALU operation
		} f;
	} opcode_t;

	localparam logic [1:0] MODE_IMM = 2'b00;
	localparam logic [1:0] MODE_DIR = 2'b01;
	localparam logic [1:0] MODE_IDX = 2'b10; // not supported, runs as NOP
	localparam logic [1:0] MODE_EXT = 2'b11;

	localparam logic [3:0] OP_SUB = 4'h0;
	localparam logic [3:0] OP_AND = 4'h4;
	localparam logic [3:0] OP_LD  = 4'h6;
	localparam logic [3:0] OP_ST  = 4'h7;
	localparam logic [3:0] OP_EOR = 4'h8;
	localparam logic [3:0] OP_OR  = 4'hA;
	localparam logic [3:0] OP_ADD = 4'hB;

	localparam logic [7:0] OPC_NOP = 8'h12;
	localparam logic [7:0] OPC_BRA = 8'h20;
	localparam logic [7:0] OPC_BNE = 8'h26;
	localparam logic [7:0] OPC_BEQ = 8'h27;
	localparam logic [7:0] OPC_JMP = 8'h7E;

	localparam int CC_C = 0;
	localparam int CC_V = 1;
	localparam int CC_Z = 2;
	localparam int CC_N = 3;

	localparam logic [15:0] RESET_VECTOR = 16'hFFFE;

	localparam logic [4:0] ST_VEC_H    = 5'd0;
	localparam logic [4:0] ST_VEC_L    = 5'd1;
	localparam logic [4:0] ST_FETCH    = 5'd2;
	localparam logic [4:0] ST_FETCH_1  = 5'd3;
	localparam logic [4:0] ST_FETCH_2  = 5'd4;
	localparam logic [4:0] ST_DECODE   = 5'd5;
	localparam logic [4:0] ST_ARG_H    = 5'd6;
	localparam logic [4:0] ST_ARG_H_1  = 5'd7;
	localparam logic [4:0] ST_ARG_H_2  = 5'd8;
	localparam logic [4:0] ST_ARG_L    = 5'd9;
	localparam logic [4:0] ST_ARG_L_1  = 5'd10;
	localparam logic [4:0] ST_ARG_L_2  = 5'd11;
	localparam logic [4:0] ST_MEM_RD   = 5'd12;
	localparam logic [4:0] ST_MEM_RD_1 = 5'd13;
	localparam logic [4:0] ST_MEM_RD_2 = 5'd14;
	localparam logic [4:0] ST_EXEC     = 5'd15;
	localparam logic [4:0] ST_WR       = 5'd16;
	localparam logic [4:0] ST_WR_1     = 5'd17;

endpackage

// ==== source/cpu_alu.sv ====
`timescale 1ns/1ps

module cpu_alu (
	input  logic [7:0] a_i, // accumulator
	input  logic [7:0] b_i, // operand byte
	input  logic [3:0] op_i,
	input  logic [3:0] cc_i,
	output logic [7:0] result_o,
	output logic [3:0] flags_o
);

	logic [8:0] sum; // bit 8 is carry or borrow
	logic       arith;
	logic       ovf;

	always_comb
	begin
		sum = 9'd0;
		arith = 1'b0;
		ovf = 1'b0;
		case (op_i)
			cpu_pkg::OP_ADD:
			begin
				sum = {1'b0, a_i} + {1'b0, b_i};
				arith = 1'b1;
				ovf = ~(a_i[7] ^ b_i[7]) & (a_i[7] ^ sum[7]); // like signs, sign flipped
			end
			cpu_pkg::OP_SUB:
			begin
				sum = {1'b0, a_i} - {1'b0, b_i};
				arith = 1'b1;
				ovf = (a_i[7] ^ b_i[7]) & (a_i[7] ^ sum[7]);
			end
			default:
				sum = 9'd0;
		endcase
	end

	always_comb
	begin
		case (op_i)
			cpu_pkg::OP_ADD, cpu_pkg::OP_SUB: result_o = sum[7:0];
			cpu_pkg::OP_AND: result_o = a_i & b_i;
			cpu_pkg::OP_OR:  result_o = a_i | b_i;
			cpu_pkg::OP_EOR: result_o = a_i ^ b_i;
			cpu_pkg::OP_LD:  result_o = b_i;
			default:         result_o = a_i; // ST passes the accumulator through
		endcase
	end

	always_comb
	begin
		flags_o = cc_i; // C survives logic ops and loads
		flags_o[cpu_pkg::CC_N] = result_o[7];
		flags_o[cpu_pkg::CC_Z] = (result_o == 8'h00);
		flags_o[cpu_pkg::CC_V] = ovf;
		if (arith)
			flags_o[cpu_pkg::CC_C] = sum[8];
	end

endmodule

// ==== source/cpu_regs.sv ====
`timescale 1ns/1ps

module cpu_regs (
	input  logic        cpu_clk,
	input  logic        k_reset,
	input  logic        pc_inc_i,
	input  logic        pc_load_i,
	input  logic [15:0] new_pc_i,
	input  logic        acc_sel_i,
	input  logic        acc_we_i,
	input  logic        cc_we_i,
	input  logic [7:0]  result_i,
	input  logic [3:0]  flags_i,
	input  logic [3:0]  br_cond_i, // low nibble of the branch opcode
	output logic [7:0]  acc_o,
	output logic [3:0]  cc_o,
	output logic [15:0] pc_o,
	output logic        cond_taken_o
);

	logic [7:0]  acc_a;
	logic [7:0]  acc_b;
	logic [3:0]  cc;
	logic [15:0] pc;

	always_ff @(posedge cpu_clk or posedge k_reset)
	begin
		if (k_reset)
		begin
			acc_a <= 8'h00;
			acc_b <= 8'h00;
			cc <= 4'h0;
			pc <= 16'h0000;
		end
		else
		begin
			if (pc_load_i)
				pc <= new_pc_i;
			else if (pc_inc_i)
				pc <= pc + 16'd1;
			if (acc_we_i && acc_sel_i)
				acc_b <= result_i;
			if (acc_we_i && !acc_sel_i)
				acc_a <= result_i;
			if (cc_we_i)
				cc <= flags_i;
		end
	end

	assign acc_o = acc_sel_i ? acc_b : acc_a; // same select for read and write back
	assign cc_o = cc;
	assign pc_o = pc;

	always_comb
	begin
		case (br_cond_i)
			cpu_pkg::OPC_BRA[3:0]: cond_taken_o = 1'b1;
			cpu_pkg::OPC_BNE[3:0]: cond_taken_o = !cc[cpu_pkg::CC_Z];
			cpu_pkg::OPC_BEQ[3:0]: cond_taken_o = cc[cpu_pkg::CC_Z];
			default:               cond_taken_o = 1'b0;
		endcase
	end

	// sequencer must never advance and reload PC in one cycle
	pc_update_exclusive: assert property (@(posedge cpu_clk) disable iff (k_reset)
		!(pc_inc_i && pc_load_i));

endmodule

// ==== source/cpu_sequencer.sv ====
`timescale 1ns/1ps

module cpu_sequencer (
	input  logic        cpu_clk,
	input  logic        k_reset,
	input  logic [7:0]  cpu_data_i,
	input  logic [7:0]  acc_i,
	input  logic [15:0] pc_i,
	input  logic        cond_taken_i,
	output logic [15:0] cpu_addr_o,
	output logic [7:0]  cpu_data_o,
	output logic        cpu_oe_o,
	output logic        cpu_we_o,
	output logic        pc_inc_o,
	output logic        pc_load_o,
	output logic [15:0] new_pc_o,
	output logic        acc_sel_o,
	output logic        acc_we_o,
	output logic        cc_we_o,
	output logic [3:0]  alu_op_o,
	output logic [7:0]  operand_o,
	output logic [3:0]  br_cond_o
);

	logic [4:0]       state;
	cpu_pkg::opcode_t opcode;
	logic [15:0]      ea;       // effective address
	logic [7:0]       operand;
	logic [15:0]      addr_r;
	logic [7:0]       data_r;
	logic             oe_r;
	logic             we_r;
	logic             op_known;
	logic             is_alu;
	logic             is_br;
	logic             is_jmp;

	always_comb
	begin
		case (opcode.f.op)
			cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_LD, cpu_pkg::OP_ST,
			cpu_pkg::OP_EOR, cpu_pkg::OP_OR, cpu_pkg::OP_ADD: op_known = 1'b1;
			default: op_known = 1'b0;
		endcase
		is_alu = opcode.f.alu_class && op_known && (opcode.f.mode != cpu_pkg::MODE_IDX)
			&& !((opcode.f.op == cpu_pkg::OP_ST) && (opcode.f.mode == cpu_pkg::MODE_IMM));
		is_br = (opcode.raw == cpu_pkg::OPC_BRA) || (opcode.raw == cpu_pkg::OPC_BNE)
			|| (opcode.raw == cpu_pkg::OPC_BEQ);
		is_jmp = (opcode.raw == cpu_pkg::OPC_JMP);
	end

	always_ff @(posedge cpu_clk or posedge k_reset)
	begin
		if (k_reset)
		begin
			state <= cpu_pkg::ST_VEC_H;
			opcode.raw <= cpu_pkg::OPC_JMP; // vector fetch runs as a JMP through FFFE
			addr_r <= 16'h0000;
			oe_r <= 1'b0;
			we_r <= 1'b0;
		end
		else
		begin
			oe_r <= 1'b0; // strobes last one cycle
			we_r <= 1'b0;
			case (state)
				cpu_pkg::ST_VEC_H:    state <= cpu_pkg::ST_ARG_H;
				cpu_pkg::ST_VEC_L:    state <= cpu_pkg::ST_FETCH;
				cpu_pkg::ST_FETCH:
				begin
					addr_r <= pc_i;
					state <= cpu_pkg::ST_FETCH_1;
				end
				cpu_pkg::ST_FETCH_1:
				begin
					oe_r <= 1'b1;
					state <= cpu_pkg::ST_FETCH_2;
				end
				cpu_pkg::ST_FETCH_2:
				begin
					opcode.raw <= cpu_data_i;
					state <= cpu_pkg::ST_DECODE;
				end
				cpu_pkg::ST_DECODE:
				begin
					if (is_jmp)
						state <= cpu_pkg::ST_ARG_H;
					else if (is_br)
						state <= cpu_pkg::ST_ARG_L; // offset byte
					else if (is_alu)
						case (opcode.f.mode)
							cpu_pkg::MODE_IMM, cpu_pkg::MODE_DIR: state <= cpu_pkg::ST_ARG_L;
							default: state <= cpu_pkg::ST_ARG_H;
						endcase
					else
						state <= cpu_pkg::ST_FETCH; // anything else is a NOP
				end
				cpu_pkg::ST_ARG_H:
				begin
					addr_r <= pc_i;
					state <= cpu_pkg::ST_ARG_H_1;
				end
				cpu_pkg::ST_ARG_H_1:
				begin
					oe_r <= 1'b1;
					state <= cpu_pkg::ST_ARG_H_2;
				end
				cpu_pkg::ST_ARG_H_2:  state <= cpu_pkg::ST_ARG_L;
				cpu_pkg::ST_ARG_L:
				begin
					addr_r <= pc_i;
					state <= cpu_pkg::ST_ARG_L_1;
				end
				cpu_pkg::ST_ARG_L_1:
				begin
					oe_r <= 1'b1;
					state <= cpu_pkg::ST_ARG_L_2;
				end
				cpu_pkg::ST_ARG_L_2:
				begin
					if (is_jmp)
						state <= cpu_pkg::ST_VEC_L; // target is in ea
					else if (is_br || (opcode.f.mode == cpu_pkg::MODE_IMM))
						state <= cpu_pkg::ST_EXEC;
					else if (opcode.f.op == cpu_pkg::OP_ST)
						state <= cpu_pkg::ST_WR;
					else
						state <= cpu_pkg::ST_MEM_RD;
				end
				cpu_pkg::ST_MEM_RD:
				begin
					addr_r <= ea;
					state <= cpu_pkg::ST_MEM_RD_1;
				end
				cpu_pkg::ST_MEM_RD_1:
				begin
					oe_r <= 1'b1;
					state <= cpu_pkg::ST_MEM_RD_2;
				end
				cpu_pkg::ST_MEM_RD_2: state <= cpu_pkg::ST_EXEC;
				cpu_pkg::ST_WR:
				begin
					addr_r <= ea;
					we_r <= 1'b1; // data_r lands in the same cycle
					state <= cpu_pkg::ST_WR_1;
				end
				default:              state <= cpu_pkg::ST_FETCH; // EXEC, WR_1
			endcase
		end
	end

	always_ff @(posedge cpu_clk)
	begin
		case (state)
			cpu_pkg::ST_DECODE:   ea[15:8] <= 8'h00; // direct page is always 0
			cpu_pkg::ST_ARG_H_2:  ea[15:8] <= cpu_data_i;
			cpu_pkg::ST_ARG_L_2:
			begin
				ea[7:0] <= cpu_data_i;
				operand <= cpu_data_i; // immediate value or branch offset
			end
			cpu_pkg::ST_MEM_RD_2: operand <= cpu_data_i;
			cpu_pkg::ST_WR:       data_r <= acc_i;
			default:              data_r <= data_r;
		endcase
	end

	always_comb
	begin
		case (state)
			cpu_pkg::ST_VEC_H: new_pc_o = cpu_pkg::RESET_VECTOR;
			cpu_pkg::ST_VEC_L: new_pc_o = ea;
			default:           new_pc_o = pc_i + {{8{operand[7]}}, operand}; // PC is past offset
		endcase
	end

	assign pc_inc_o = (state == cpu_pkg::ST_FETCH) || (state == cpu_pkg::ST_ARG_H)
		|| (state == cpu_pkg::ST_ARG_L);
	assign pc_load_o = (state == cpu_pkg::ST_VEC_H) || (state == cpu_pkg::ST_VEC_L)
		|| ((state == cpu_pkg::ST_EXEC) && is_br && cond_taken_i);
	assign acc_we_o = (state == cpu_pkg::ST_EXEC) && is_alu;
	assign cc_we_o = acc_we_o || (state == cpu_pkg::ST_WR_1); // ST updates N and Z
	assign acc_sel_o = opcode.f.acc_sel;
	assign alu_op_o = opcode.f.op;
	assign operand_o = operand;
	assign br_cond_o = opcode.raw[3:0];

	assign cpu_addr_o = addr_r;
	assign cpu_data_o = data_r;
	assign cpu_oe_o = oe_r;
	assign cpu_we_o = we_r;

	strobe_no_overlap: assert property (@(posedge cpu_clk) disable iff (k_reset)
		!(cpu_oe_o && cpu_we_o));
	oe_single_cycle: assert property (@(posedge cpu_clk) disable iff (k_reset)
		cpu_oe_o |=> !cpu_oe_o);
	we_single_cycle: assert property (@(posedge cpu_clk) disable iff (k_reset)
		cpu_we_o |=> !cpu_we_o);

endmodule

// ==== source/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
	input  logic        cpu_clk,
	input  logic        k_reset,
	input  logic [7:0]  cpu_data_i,
	output logic [15:0] cpu_addr_o,
	output logic [7:0]  cpu_data_o,
	output logic        cpu_oe_o,
	output logic        cpu_we_o
);

	logic        pc_inc;
	logic        pc_load;
	logic [15:0] new_pc;
	logic        acc_sel;
	logic        acc_we;
	logic        cc_we;
	logic [3:0]  alu_op;
	logic [7:0]  operand;
	logic [3:0]  br_cond;
	logic [7:0]  acc;
	logic [3:0]  cc;
	logic [15:0] pc;
	logic        cond_taken;
	logic [7:0]  result;
	logic [3:0]  flags;

	cpu_sequencer cpu_sequencer_inst (
		.cpu_clk(cpu_clk), .k_reset(k_reset), .cpu_data_i(cpu_data_i),
		.acc_i(acc), .pc_i(pc), .cond_taken_i(cond_taken),
		.cpu_addr_o(cpu_addr_o), .cpu_data_o(cpu_data_o),
		.cpu_oe_o(cpu_oe_o), .cpu_we_o(cpu_we_o),
		.pc_inc_o(pc_inc), .pc_load_o(pc_load), .new_pc_o(new_pc),
		.acc_sel_o(acc_sel), .acc_we_o(acc_we), .cc_we_o(cc_we),
		.alu_op_o(alu_op), .operand_o(operand), .br_cond_o(br_cond)
	);

	cpu_regs cpu_regs_inst (
		.cpu_clk(cpu_clk), .k_reset(k_reset),
		.pc_inc_i(pc_inc), .pc_load_i(pc_load), .new_pc_i(new_pc),
		.acc_sel_i(acc_sel), .acc_we_i(acc_we), .cc_we_i(cc_we),
		.result_i(result), .flags_i(flags), .br_cond_i(br_cond),
		.acc_o(acc), .cc_o(cc), .pc_o(pc), .cond_taken_o(cond_taken)
	);

	cpu_alu cpu_alu_inst (
		.a_i(acc), .b_i(operand), .op_i(alu_op), .cc_i(cc),
		.result_o(result), .flags_o(flags)
	);

endmodule

// ==== test/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
	input  logic        cpu_clk,
	input  logic        k_reset,
	input  logic        image_ready_i,
	input  logic [15:0] cpu_addr_i,
	input  logic [7:0]  cpu_data_i, // DUT write data
	input  logic        cpu_oe_i,
	input  logic        cpu_we_i,
	output logic        done_o,
	output int          value_errors_o,
	output int          protocol_errors_o
);

	localparam int MAX_STEPS = 1000;

	logic [7:0]  image [0:65535]; // model copy of memory
	logic [15:0] rd_addr_q [$];
	string       rd_name_q [$];
	logic [15:0] wr_addr_q [$];
	logic [7:0]  wr_data_q [$];
	logic        finished = 1'b0;
	logic        oe_prev = 1'b0;
	logic        we_prev = 1'b0;
	int          value_errors = 0;
	int          protocol_errors = 0;

	assign done_o = finished;
	assign value_errors_o = value_errors;
	assign protocol_errors_o = protocol_errors;

	task automatic report_value(input string name, input logic [15:0] exp,
		input logic [15:0] act);
		$display("FAILED %s: expected %h, actual %h", name, exp, act);
		value_errors++;
	endtask

	task automatic report_problem(input string what);
		$display("ERROR at %0t: %s", $time, what);
		protocol_errors++;
	endtask

	task automatic expect_read(input logic [15:0] addr, input string name);
		rd_addr_q.push_back(addr);
		rd_name_q.push_back(name);
	endtask

	task automatic fetch_arg(inout logic [15:0] pc, output logic [7:0] b);
		expect_read(pc, "operand");
		b = image[pc];
		pc = pc + 16'd1;
	endtask

	function automatic logic alu_instr(input cpu_pkg::opcode_t opc);
		logic known;
		case (opc.f.op)
			cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_LD, cpu_pkg::OP_ST,
			cpu_pkg::OP_EOR, cpu_pkg::OP_OR, cpu_pkg::OP_ADD: known = 1'b1;
			default: known = 1'b0;
		endcase
		return opc.f.alu_class && known && (opc.f.mode != cpu_pkg::MODE_IDX)
			&& !((opc.f.op == cpu_pkg::OP_ST) && (opc.f.mode == cpu_pkg::MODE_IMM));
	endfunction

	task automatic alu_model(input logic [3:0] op, input logic [7:0] a, input logic [7:0] b,
		inout logic [3:0] cc, output logic [7:0] r);
		logic [8:0] wide;
		logic       v;
		v = 1'b0;
		case (op)
			cpu_pkg::OP_ADD:
			begin
				wide = {1'b0, a} + {1'b0, b};
				r = wide[7:0];
				cc[cpu_pkg::CC_C] = wide[8];
				v = (a[7] == b[7]) && (r[7] != a[7]);
			end
			cpu_pkg::OP_SUB:
			begin
				r = a - b;
				cc[cpu_pkg::CC_C] = (b > a); // borrow
				v = (a[7] != b[7]) && (r[7] != a[7]);
			end
			cpu_pkg::OP_AND: r = a & b;
			cpu_pkg::OP_OR:  r = a | b;
			cpu_pkg::OP_EOR: r = a ^ b;
			cpu_pkg::OP_LD:  r = b;
			default:         r = a; // store keeps the accumulator
		endcase
		cc[cpu_pkg::CC_N] = r[7];
		cc[cpu_pkg::CC_Z] = (r == 8'h00);
		cc[cpu_pkg::CC_V] = v;
	endtask

	task automatic run_model();
		cpu_pkg::opcode_t opc;
		logic [15:0] pc;
		logic [15:0] here;
		logic [15:0] ea;
		logic [7:0]  acc_a;
		logic [7:0]  acc_b;
		logic [7:0]  operand;
		logic [7:0]  res;
		logic [3:0]  cc;
		logic        taken;
		logic        parked;
		int          steps;
		expect_read(16'hFFFE, "reset_vector");
		expect_read(16'hFFFF, "reset_vector");
		pc = {image[16'hFFFE], image[16'hFFFF]};
		acc_a = 8'h00;
		acc_b = 8'h00;
		cc = 4'h0;
		ea = 16'h0000;
		operand = 8'h00;
		parked = 1'b0;
		steps = 0;
		while (!parked && steps < MAX_STEPS)
		begin
			here = pc;
			expect_read(pc, "fetch");
			opc.raw = image[pc];
			pc = pc + 16'd1;
			steps++;
			if (opc.raw == cpu_pkg::OPC_JMP)
			begin
				fetch_arg(pc, ea[15:8]);
				fetch_arg(pc, ea[7:0]);
				parked = (ea == here);
				pc = ea;
			end
			else if (opc.raw == cpu_pkg::OPC_BRA || opc.raw == cpu_pkg::OPC_BNE
				|| opc.raw == cpu_pkg::OPC_BEQ)
			begin
				fetch_arg(pc, operand);
				case (opc.raw)
					cpu_pkg::OPC_BNE: taken = !cc[cpu_pkg::CC_Z];
					cpu_pkg::OPC_BEQ: taken = cc[cpu_pkg::CC_Z];
					default:          taken = 1'b1;
				endcase
				if (taken)
					pc = pc + {{8{operand[7]}}, operand}; // relative to the next opcode
			end
			else if (alu_instr(opc))
			begin
				case (opc.f.mode)
					cpu_pkg::MODE_IMM: fetch_arg(pc, operand);
					cpu_pkg::MODE_DIR:
					begin
						ea[15:8] = 8'h00; // page 0
						fetch_arg(pc, ea[7:0]);
					end
					default:
					begin
						fetch_arg(pc, ea[15:8]);
						fetch_arg(pc, ea[7:0]);
					end
				endcase
				res = opc.f.acc_sel ? acc_b : acc_a;
				if (opc.f.op == cpu_pkg::OP_ST)
				begin
					wr_addr_q.push_back(ea);
					wr_data_q.push_back(res);
					image[ea] = res;
				end
				else if (opc.f.mode != cpu_pkg::MODE_IMM)
				begin
					expect_read(ea, "data_read");
					operand = image[ea];
				end
				alu_model(opc.f.op, res, operand, cc, res);
				if (opc.f.acc_sel)
					acc_b = res;
				else
					acc_a = res;
			end
		end
		if (parked)
			expect_read(pc, "fetch"); // the parked jump comes round again
		else
			report_problem("model found no jump to itself within the step limit");
	endtask

	task automatic load_image();
		int i;
		for (i = 0; i < 65536; i++)
			image[i] = tb_top.mem[i];
	endtask

	task automatic check_read();
		if (rd_addr_q.size() == 0)
			report_problem("read strobe with no read left in the model");
		else
		begin
			if (cpu_addr_i != rd_addr_q[0])
				report_value(rd_name_q[0], rd_addr_q[0], cpu_addr_i);
			void'(rd_addr_q.pop_front());
			void'(rd_name_q.pop_front());
			if (rd_addr_q.size() == 0)
			begin
				finished = 1'b1;
				if (wr_addr_q.size() != 0)
					report_problem($sformatf("%0d expected stores never happened",
						wr_addr_q.size()));
			end
		end
	endtask

	task automatic check_write();
		if (wr_addr_q.size() == 0)
			report_problem("write strobe outside any store instruction");
		else
		begin
			if (cpu_addr_i != wr_addr_q[0])
				report_value("store_address", wr_addr_q[0], cpu_addr_i);
			if (cpu_data_i != wr_data_q[0])
				report_value("alu_result", {8'h00, wr_data_q[0]}, {8'h00, cpu_data_i});
			void'(wr_addr_q.pop_front());
			void'(wr_data_q.pop_front());
		end
	endtask

	initial
	begin
		wait (image_ready_i);
		load_image();
		run_model();
	end

	// strobes and address are stable mid cycle
	always @(negedge cpu_clk)
	begin
		if (!k_reset)
		begin
			if (cpu_oe_i && cpu_we_i)
				report_problem("read and write strobes high in the same cycle");
			if (cpu_oe_i && oe_prev)
				report_problem("read strobe high for two cycles in a row");
			if (cpu_we_i && we_prev)
				report_problem("write strobe high for two cycles in a row");
			if (cpu_oe_i)
				check_read();
			if (cpu_we_i)
				check_write();
		end
		oe_prev = cpu_oe_i;
		we_prev = cpu_we_i;
	end

endmodule

// ==== test/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_INSTR = 200;
	localparam int TIMEOUT_NS = (NUM_INSTR * 20 + RESET_CYCLES) * CLK_PERIOD;

	logic        cpu_clk;
	logic        k_reset;
	logic [7:0]  cpu_data_i;
	logic [15:0] cpu_addr_o;
	logic [7:0]  cpu_data_o;
	logic        cpu_oe_o;
	logic        cpu_we_o;
	logic        image_ready;
	logic        done;
	int          value_errors;
	int          protocol_errors;
	int          timeouts;
	integer      seed;
	logic [15:0] gen_addr; // next free program byte
	logic [7:0]  mem [0:65535];

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % n);
	endfunction

	task automatic emit(input logic [7:0] b);
		mem[gen_addr] = b;
		gen_addr = gen_addr + 16'd1;
	endtask

	task automatic build_program();
		int          i;
		int          count;
		int          k;
		logic [7:0]  r;
		logic [1:0]  mode;
		logic [3:0]  op;
		logic [15:0] target;
		for (i = 0; i < 65536; i++)
			mem[i] = rand_byte();
		mem[16'hFFFE] = 8'h01; // program starts at 0100
		mem[16'hFFFF] = 8'h00;
		gen_addr = 16'h0100;
		count = 0;
		while (count < NUM_INSTR - 5)
		begin
			if (rand_below(4) != 0)
			begin
				r = rand_byte(); // bit 0 picks A or B
				case (rand_below(3))
					0: mode = cpu_pkg::MODE_IMM;
					1: mode = cpu_pkg::MODE_DIR;
					default: mode = cpu_pkg::MODE_EXT;
				endcase
				case (rand_below(6))
					0: op = cpu_pkg::OP_SUB;
					1: op = cpu_pkg::OP_AND;
					2: op = cpu_pkg::OP_LD;
					3: op = cpu_pkg::OP_EOR;
					4: op = cpu_pkg::OP_OR;
					default: op = cpu_pkg::OP_ADD;
				endcase
				emit({1'b1, r[0], mode, op});
				if (mode == cpu_pkg::MODE_EXT && rand_below(2) == 0)
					emit(8'h20); // read back from the store area
				else if (mode == cpu_pkg::MODE_EXT)
					emit(rand_byte());
				emit(rand_byte());
				emit({1'b1, r[0], cpu_pkg::MODE_EXT, cpu_pkg::OP_ST});
				emit(8'h20);
				emit(rand_byte());
				count = count + 2;
			end
			else
			begin
				k = rand_below(4);
				case (rand_below(3))
					0: emit(cpu_pkg::OPC_BRA);
					1: emit(cpu_pkg::OPC_BNE);
					default: emit(cpu_pkg::OPC_BEQ);
				endcase
				emit(8'(k)); // forward skip over the filler
				repeat (k) emit(cpu_pkg::OPC_NOP);
				count = count + 1 + k;
			end
		end
		target = gen_addr;
		emit(cpu_pkg::OPC_JMP); // park on a jump to itself
		emit(target[15:8]);
		emit(target[7:0]);
	endtask

	task automatic finish_run();
		$display("errors: value %0d, protocol %0d, timeout %0d",
			value_errors, protocol_errors, timeouts);
		if (value_errors == 0 && protocol_errors == 0 && timeouts == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	endtask

	initial
	begin
		cpu_clk = 1'b0;
		forever #(CLK_PERIOD / 2) cpu_clk = ~cpu_clk;
	end

	initial
	begin
		k_reset = 1'b1;
		cpu_data_i = 8'h00;
		image_ready = 1'b0;
		seed = 62;
		build_program();
		image_ready = 1'b1;
		repeat (RESET_CYCLES) @(negedge cpu_clk);
		k_reset = 1'b0;
		wait (done);
		repeat (2) @(negedge cpu_clk);
		finish_run();
	end

	initial
	begin
		timeouts = 0;
		#(TIMEOUT_NS);
		$display("timeout: the final jump was not reached within %0d ns", TIMEOUT_NS);
		timeouts = 1;
		finish_run();
	end

	always @(negedge cpu_clk)
		cpu_data_i <= mem[cpu_addr_o]; // valid well before the sampling edge

	always @(posedge cpu_clk)
		if (cpu_we_o)
			mem[cpu_addr_o] <= cpu_data_o;

	cpu_top cpu_top_inst (
		.cpu_clk(cpu_clk), .k_reset(k_reset), .cpu_data_i(cpu_data_i),
		.cpu_addr_o(cpu_addr_o), .cpu_data_o(cpu_data_o),
		.cpu_oe_o(cpu_oe_o), .cpu_we_o(cpu_we_o)
	);

	tb_checker checker_inst (
		.cpu_clk(cpu_clk), .k_reset(k_reset), .image_ready_i(image_ready),
		.cpu_addr_i(cpu_addr_o), .cpu_data_i(cpu_data_o),
		.cpu_oe_i(cpu_oe_o), .cpu_we_i(cpu_we_o),
		.done_o(done), .value_errors_o(value_errors), .protocol_errors_o(protocol_errors)
	);

endmodule

// ==== list.f ====
source/cpu_pkg.sv
source/cpu_alu.sv
source/cpu_regs.sv
source/cpu_sequencer.sv
source/cpu_top.sv
test/tb_checker.sv
test/tb_top.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_top
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: build
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then echo "run failed"; exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
